// File: design/cp0_config.svh
`ifndef CP0_CONFIG_SVH
`define CP0_CONFIG_SVH

// Machine word, shared by CP0 and GPR data
`define CP0_DATA_WIDTH 32

// CP0 register numbers, all at select 0
`define CP0_REG_BADVADDR 5'd8
`define CP0_REG_COUNT    5'd9
`define CP0_REG_COMPARE  5'd11
`define CP0_REG_STATUS   5'd12
`define CP0_REG_CAUSE    5'd13
`define CP0_REG_EPC      5'd14

// Exception vector bases, picked by Status.BEV
`define CP0_VEC_BOOT_BASE   32'hBFC0_0200
`define CP0_VEC_NORMAL_BASE 32'h8000_0000

`define CP0_VEC_GENERAL_OFFSET 32'h0000_0180 // All general exceptions
`define CP0_VEC_SPECIAL_OFFSET 32'h0000_0200 // Interrupts when Cause.IV is set
`define CP0_RESET_VECTOR       32'hBFC0_0000

`endif

// File: design/cp0RegsPkg.sv
`default_nettype none

`include "cp0_config.svh"

package cp0RegsPkg;

    typedef logic [`CP0_DATA_WIDTH-1:0] dataT; // One CP0 or GPR word
    typedef logic [4:0] regIndexT;             // rd field of mfc0/mtc0

    // Cause.ExcCode values this core can raise
    typedef enum logic [4:0] {
        INT  = 5'd0,
        ADEL = 5'd4,  // Load or fetch address error
        ADES = 5'd5,  // Store address error
        SYS  = 5'd8,
        BP   = 5'd9,
        RI   = 5'd10,
        CPU  = 5'd11, // CP0 access from user mode
        OV   = 5'd12,
        TR   = 5'd13
    } excCodeT;

    // Status at architectural bit positions, reserved bits read zero
    typedef struct packed {
        logic [8:0] rsvd31;
        logic       bev;    // 22, boot vectors
        logic [5:0] rsvd21;
        logic [7:0] im;     // 15:8, interrupt mask
        logic [2:0] rsvd7;
        logic       um;     // 4, user mode
        logic [1:0] rsvd3;
        logic       exl;    // 1, exception level
        logic       ie;     // 0, global interrupt enable
    } statusT;

    typedef struct packed {
        logic       bd;      // 31, exception in delay slot
        logic [6:0] rsvd30;
        logic       iv;      // 23, special interrupt vector
        logic [6:0] rsvd22;
        logic [7:0] ip;      // 15:8, pending interrupts
        logic       rsvd7;
        excCodeT    excCode; // 6:2
        logic [1:0] rsvd1;
    } causeT;

endpackage

`default_nettype wire

// File: design/pipeExcPkg.sv
`default_nettype none

package pipeExcPkg;

    // Per-stage exception context from the pipeline registers
    typedef struct packed {
        cp0RegsPkg::dataT restartPc; // Branch PC when in a delay slot
        logic             isBd;
        logic             canErr;    // Stage or anything ahead may still fault
    } stageInfoT;

    // Raw exception strobes, one per cause
    typedef struct packed {
        logic adIf;
        logic adEl;
        logic adEs;
        logic ov;
        logic tr;
        logic sys;
        logic bp;
        logic ri;
    } excRaiseT;

    typedef struct packed {
        logic [3:0] stall; // IF=0, ID=1, EX=2, MEM=3
        logic [3:0] flush;
    } stageCtrlT;

    // CP0 instruction sitting in ID
    typedef struct packed {
        logic                 mfc0;
        logic                 mtc0;
        logic                 eret;
        cp0RegsPkg::regIndexT rd;
        logic [2:0]           sel;
        cp0RegsPkg::dataT     writeData;
    } cp0AccessT;

    // Exception committed into CP0 at the next edge
    typedef struct packed {
        logic                valid;
        cp0RegsPkg::excCodeT code;
        cp0RegsPkg::dataT    epc;
        logic                isBd;
        cp0RegsPkg::dataT    badAddr;
        logic                loadBadAddr; // Only address errors update BadVAddr
    } excTakeT;

endpackage

`default_nettype wire

// File: design/exceptionArbiter.sv
`timescale 1ns/1ps
`default_nettype none

module exceptionArbiter (
    input  wire logic                  clock,
    input  wire logic                  reset,
    input  wire pipeExcPkg::cp0AccessT access,
    input  wire pipeExcPkg::excRaiseT  raise,
    input  wire pipeExcPkg::stageInfoT idInfo,
    input  wire pipeExcPkg::stageInfoT exInfo,
    input  wire pipeExcPkg::stageInfoT memInfo,
    input  wire logic                  ifIsBd,
    input  wire logic                  ifCanErr,
    input  wire cp0RegsPkg::dataT      badAddrIf,
    input  wire cp0RegsPkg::dataT      badAddrMem,
    input  wire logic                  ifStall,
    input  wire logic                  idStall,
    input  wire logic                  cp0Usable,
    input  wire logic                  intRequest,
    output pipeExcPkg::stageCtrlT      control,
    output pipeExcPkg::excTakeT        take,
    output logic                       writeCommit,
    output logic                       eretCommit,
    output logic                       anyException,
    output logic                       anyReady
);

    logic       cpU;       // Privileged CP0 op in user mode
    logic       resetDelay;
    logic [3:0] detect;    // Bit per stage with MEM at 3
    logic [3:0] fwdDetect; // Some stage ahead has an exception
    logic [3:0] mask;      // Stage must wait for the stages ahead
    logic [3:0] hold;      // Exceptions plus CP0 writes that may need to wait
    logic [3:0] ready;
    cp0RegsPkg::excCodeT code;

    always_ff @(posedge clock) begin
        resetDelay <= reset; // Keeps IF flushed on the first fetch after reset
    end

    assign cpU = (access.mfc0 | access.mtc0 | access.eret) & ~cp0Usable;

    assign detect[3] = raise.adEl | raise.adEs | raise.tr;
    assign detect[2] = raise.ov;
    assign detect[1] = raise.sys | raise.bp | raise.ri | cpU | intRequest; // Interrupts enter in ID
    assign detect[0] = raise.adIf;

    assign fwdDetect = {1'b0, detect[3], |detect[3:2], |detect[3:1]};

    // Stages wait on forward canErr and IF also waits for an interrupt to go first
    assign mask[3] = ifStall;
    assign mask[2] = ifStall | memInfo.canErr;
    assign mask[1] = ifStall | memInfo.canErr | exInfo.canErr;
    assign mask[0] = memInfo.canErr | exInfo.canErr | idInfo.canErr | intRequest;

    assign hold = {detect[3:2], detect[1] | access.mtc0 | access.eret, detect[0]};

    assign control.stall = hold & mask & ~fwdDetect; // A forward exception flushes instead
    assign ready         = detect & ~mask & ~fwdDetect & {4{~idStall}};

    assign control.flush[3:1] = detect[3:1] | fwdDetect[3:1];
    assign control.flush[0]   = detect[0] | fwdDetect[0] | eretCommit | resetDelay;

    // A flushed ID never writes CP0
    assign writeCommit  = access.mtc0 & cp0Usable & ~idStall & ~control.flush[1];
    assign eretCommit   = access.eret & ~idStall;
    // Any cause that outranks a plain interrupt
    assign anyException = |detect[3:2] | detect[0] | raise.sys | raise.bp | raise.ri | cpU;
    assign anyReady     = |ready;

    // Forward-most cause first and interrupt last
    always_comb begin
        if      (raise.adEl) code = cp0RegsPkg::ADEL;
        else if (raise.adEs) code = cp0RegsPkg::ADES;
        else if (raise.tr)   code = cp0RegsPkg::TR;
        else if (raise.ov)   code = cp0RegsPkg::OV;
        else if (raise.sys)  code = cp0RegsPkg::SYS;
        else if (raise.bp)   code = cp0RegsPkg::BP;
        else if (raise.ri)   code = cp0RegsPkg::RI;
        else if (cpU)        code = cp0RegsPkg::CPU;
        else if (raise.adIf) code = cp0RegsPkg::ADEL; // Fetch error reports as AdEL
        else                 code = cp0RegsPkg::INT;
    end

    always_comb begin
        take       = '0;
        take.valid = anyReady;
        take.code  = code;
        if (ready[3]) begin
            take.epc         = memInfo.restartPc;
            take.isBd        = memInfo.isBd;
            take.badAddr     = badAddrMem;
            take.loadBadAddr = raise.adEl | raise.adEs; // Not for traps
        end else if (ready[2]) begin
            take.epc  = exInfo.restartPc;
            take.isBd = exInfo.isBd;
        end else if (ready[1]) begin
            take.epc  = idInfo.restartPc;
            take.isBd = idInfo.isBd;
        end else if (ready[0]) begin
            take.epc         = badAddrIf; // Faulting fetch PC
            take.isBd        = ifIsBd;
            take.badAddr     = badAddrIf;
            take.loadBadAddr = 1'b1;
        end
    end

    // Priority plus masking must leave a single stage to commit
    oneReady: assert property (@(posedge clock) disable iff (reset) $onehot0(ready));

    // Fetch unit only faults when it has flagged the risk to the stages behind
    fetchErrFlagged: assert property (@(posedge clock) disable iff (reset)
        raise.adIf |-> ifCanErr);

endmodule

`default_nettype wire

// File: design/cp0RegisterFile.sv
`timescale 1ns/1ps
`default_nettype none

`include "cp0_config.svh"

module cp0RegisterFile (
    input  wire logic                  clock,
    input  wire logic                  reset,
    input  wire pipeExcPkg::cp0AccessT access,
    input  wire pipeExcPkg::excTakeT   take,
    input  wire logic                  writeCommit,
    input  wire logic                  eretCommit,
    input  wire logic                  idIsFlushed,
    input  wire logic [4:0]            hwInt,
    output cp0RegsPkg::dataT           readData,
    output cp0RegsPkg::statusT         status,
    output logic                       causeIv,
    output cp0RegsPkg::dataT           epc,
    output logic [7:0]                 pending,
    output logic                       cp0Usable,
    output logic                       kernelMode,
    output logic                       intRequest
);

    cp0RegsPkg::causeT cause;
    cp0RegsPkg::dataT  count;
    cp0RegsPkg::dataT  compare;
    cp0RegsPkg::dataT  badVAddr;
    cp0RegsPkg::dataT  wData;
    logic              wrSel0;
    logic              timerHit;

    assign wData    = access.writeData;
    assign wrSel0   = writeCommit & (access.sel == 3'd0); // Only select 0 is writable
    assign timerHit = count == compare;

    assign kernelMode = ~status.um | status.exl;
    assign cp0Usable  = kernelMode;
    assign intRequest = status.ie & |(cause.ip & status.im) & ~status.exl & ~idIsFlushed;
    assign pending    = cause.ip;
    assign causeIv    = cause.iv;

    always_ff @(posedge clock) begin
        if (reset) begin
            status <= '{bev: 1'b1, default: '0}; // Boot vectors until software moves them
        end else if (take.valid) begin
            status.exl <= 1'b1;
        end else if (wrSel0 && access.rd == `CP0_REG_STATUS) begin
            status.bev <= wData[22];
            status.im  <= wData[15:8];
            status.um  <= wData[4];
            status.exl <= wData[1];
            status.ie  <= wData[0];
        end else if (eretCommit) begin
            status.exl <= 1'b0;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            cause <= '0;
        end else begin
            // Timer line is sticky until Compare is rewritten
            if (wrSel0 && access.rd == `CP0_REG_COMPARE)
                cause.ip[7] <= 1'b0;
            else if (timerHit)
                cause.ip[7] <= 1'b1;
            cause.ip[6:2] <= hwInt; // Level sampled, one cycle late
            if (wrSel0 && access.rd == `CP0_REG_CAUSE) begin
                cause.iv      <= wData[23];
                cause.ip[1:0] <= wData[9:8]; // Software interrupts
            end
            if (take.valid) begin
                cause.excCode <= take.code;
                if (!status.exl)
                    cause.bd <= take.isBd; // Nested exception keeps the first BD
            end
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            count   <= '0;
            compare <= '0;
        end else begin
            if (wrSel0 && access.rd == `CP0_REG_COUNT)
                count <= wData;
            else
                count <= count + 1'b1;
            if (wrSel0 && access.rd == `CP0_REG_COMPARE)
                compare <= wData;
        end
    end

    always_ff @(posedge clock) begin
        if (take.valid && !status.exl)
            epc <= take.epc;
        else if (wrSel0 && access.rd == `CP0_REG_EPC)
            epc <= wData;
        if (take.valid && take.loadBadAddr)
            badVAddr <= take.badAddr;
    end

    // mfc0 read, unimplemented registers and selects read zero
    always_comb begin
        readData = '0;
        if (access.mfc0 && cp0Usable && access.sel == 3'd0) begin
            case (access.rd)
                `CP0_REG_BADVADDR: readData = badVAddr;
                `CP0_REG_COUNT:    readData = count;
                `CP0_REG_COMPARE:  readData = compare;
                `CP0_REG_STATUS:   readData = status;
                `CP0_REG_CAUSE:    readData = cause;
                `CP0_REG_EPC:      readData = epc;
                default:           readData = '0;
            endcase
        end
    end

    // Arbiter blocks mtc0 whenever it commits an exception
    noWriteOnTake: assert property (@(posedge clock) disable iff (reset)
        !(take.valid && writeCommit));

endmodule

`default_nettype wire

// File: design/exceptionVector.sv
`timescale 1ns/1ps
`default_nettype none

`include "cp0_config.svh"

module exceptionVector (
    input  wire logic               reset,
    input  wire logic               eretCommit,
    input  wire logic               anyException,
    input  wire logic               anyReady,
    input  wire cp0RegsPkg::statusT status,
    input  wire logic               causeIv,
    input  wire cp0RegsPkg::dataT   epc,
    input  wire logic               intRequest,
    output cp0RegsPkg::dataT        excPc,
    output logic                    excPcSel
);

    cp0RegsPkg::dataT base;

    assign base = status.bev ? `CP0_VEC_BOOT_BASE : `CP0_VEC_NORMAL_BASE;

    always_comb begin
        if (reset)
            excPc = `CP0_RESET_VECTOR;
        else if (eretCommit)
            excPc = epc; // Return from handler
        else if (intRequest && causeIv && !anyException)
            excPc = base + `CP0_VEC_SPECIAL_OFFSET; // Dedicated interrupt entry
        else
            excPc = base + `CP0_VEC_GENERAL_OFFSET;
    end

    // Redirect only when something actually commits
    assign excPcSel = reset | eretCommit | anyReady;

endmodule

`default_nettype wire

// File: design/cpZero.sv
`timescale 1ns/1ps
`default_nettype none

module cpZero (
    input  wire logic                  clock,
    input  wire logic                  reset,
    input  wire pipeExcPkg::cp0AccessT access,
    input  wire pipeExcPkg::excRaiseT  raise,
    input  wire pipeExcPkg::stageInfoT idInfo,
    input  wire pipeExcPkg::stageInfoT exInfo,
    input  wire pipeExcPkg::stageInfoT memInfo,
    input  wire logic                  ifIsBd,
    input  wire logic                  ifCanErr,
    input  wire cp0RegsPkg::dataT      badAddrIf,
    input  wire cp0RegsPkg::dataT      badAddrMem,
    input  wire logic                  ifStall,
    input  wire logic                  idStall,
    input  wire logic                  idIsFlushed,
    input  wire logic [4:0]            hwInt,
    output cp0RegsPkg::dataT           readData,
    output logic                       kernelMode,
    output pipeExcPkg::stageCtrlT      control,
    output cp0RegsPkg::dataT           excPc,
    output logic                       excPcSel,
    output logic [7:0]                 pending
);

    pipeExcPkg::excTakeT take;
    cp0RegsPkg::statusT  status;
    cp0RegsPkg::dataT    epc;
    logic                cp0Usable;
    logic                intRequest;
    logic                writeCommit;
    logic                eretCommit;
    logic                anyException;
    logic                anyReady;
    logic                causeIv;

    exceptionArbiter exceptionArbiter_inst (
        .clock, .reset, .access, .raise, .idInfo, .exInfo, .memInfo,
        .ifIsBd, .ifCanErr, .badAddrIf, .badAddrMem, .ifStall, .idStall,
        .cp0Usable, .intRequest, .control, .take, .writeCommit, .eretCommit,
        .anyException, .anyReady
    );

    cp0RegisterFile cp0RegisterFile_inst (
        .clock, .reset, .access, .take, .writeCommit, .eretCommit, .idIsFlushed,
        .hwInt, .readData, .status, .causeIv, .epc, .pending, .cp0Usable,
        .kernelMode, .intRequest
    );

    exceptionVector exceptionVector_inst (
        .reset, .eretCommit, .anyException, .anyReady, .status, .causeIv,
        .epc, .intRequest, .excPc, .excPcSel
    );

endmodule

`default_nettype wire

// File: bench/cpZeroChecks.svh
`ifndef CPZERO_CHECKS_SVH
`define CPZERO_CHECKS_SVH

int    checkCount  = 0;
int    errorCount  = 0;
int    testsRun    = 0;
int    testsFailed = 0;
int    errorsAtStart;
string testName;

task automatic startTest(input string name);
    testName      = name;
    errorsAtStart = errorCount; // Errors of this test only
    testsRun++;
endtask

task automatic finishTest();
    if (errorCount == errorsAtStart) begin
        $display("PASS %s", testName);
    end else begin
        testsFailed++;
        $display("FAIL %s with %0d errors", testName, errorCount - errorsAtStart);
    end
endtask

task automatic reportFailure(input string what);
    errorCount++;
    $display("%s: %s", testName, what);
endtask

task automatic checkData(input string what, input cp0RegsPkg::dataT expected,
                         input cp0RegsPkg::dataT actual);
    checkCount++;
    if (actual !== expected) begin
        errorCount++;
        $display("ERR %s %s: expected %h, actual %h", testName, what, expected, actual);
    end
endtask

task automatic checkFlag(input string what, input logic expected, input logic actual);
    checkCount++;
    if (actual !== expected) begin
        errorCount++;
        $display("ERR %s %s: expected %b, actual %b", testName, what, expected, actual);
    end
endtask

task automatic checkCode(input string what, input cp0RegsPkg::excCodeT expected,
                         input cp0RegsPkg::excCodeT actual);
    checkCount++;
    if (actual !== expected) begin
        errorCount++;
        $display("ERR %s %s: expected %0d, actual %0d", testName, what, expected, actual);
    end
endtask

task automatic checkCtrl(input string what, input pipeExcPkg::stageCtrlT expected,
                         input pipeExcPkg::stageCtrlT actual);
    checkCount++;
    if (actual !== expected) begin
        errorCount++;
        $display("ERR %s %s: expected stall %b flush %b, actual stall %b flush %b",
                 testName, what, expected.stall, expected.flush, actual.stall, actual.flush);
    end
endtask

function automatic pipeExcPkg::stageCtrlT makeCtrl(input logic [3:0] stall,
                                                   input logic [3:0] flush);
    pipeExcPkg::stageCtrlT ctrl;
    ctrl.stall = stall; // Bit 0 is IF, bit 3 is MEM
    ctrl.flush = flush;
    return ctrl;
endfunction

// Quiet pipeline, nothing raised and nothing stalled
task automatic idleInputs();
    access      = '0;
    raise       = '0;
    idInfo      = '0;
    exInfo      = '0;
    memInfo     = '0;
    ifIsBd      = 1'b0;
    ifCanErr    = 1'b0;
    badAddrIf   = '0;
    badAddrMem  = '0;
    ifStall     = 1'b0;
    idStall     = 1'b0;
    idIsFlushed = 1'b0;
    hwInt       = '0;
endtask

task automatic nextCycle();
    @(posedge clock);
    #1; // Drive point
endtask

// mfc0 in ID for one cycle, data sampled once settled
task automatic readReg(input cp0RegsPkg::regIndexT rd, output cp0RegsPkg::dataT value);
    access.mfc0 = 1'b1;
    access.rd   = rd;
    access.sel  = 3'd0;
    #2;
    value = readData;
    nextCycle();
    access = '0;
endtask

task automatic writeReg(input cp0RegsPkg::regIndexT rd, input cp0RegsPkg::dataT value);
    access.mtc0      = 1'b1;
    access.rd        = rd;
    access.sel       = 3'd0;
    access.writeData = value;
    nextCycle(); // Commits at this edge
    access = '0;
endtask

task automatic returnFromException();
    access.eret = 1'b1;
    nextCycle();
    access = '0;
endtask

`endif

// File: bench/cpZeroTb.sv
`timescale 1ns/1ps
`default_nettype none

`include "cp0_config.svh"

module cpZeroTb;

    localparam int clockPeriod   = 10;
    localparam int resetCycles   = 10;
    localparam int testCount     = 6;
    localparam int cyclesPerTest = 200;

    localparam cp0RegsPkg::dataT statusReset   = 32'h0040_0000; // BEV only
    localparam cp0RegsPkg::dataT statusLive    = 32'h0040_FF13; // BEV, IM, UM, EXL, IE
    localparam cp0RegsPkg::dataT statusExl     = 32'h0000_0002;
    localparam cp0RegsPkg::dataT generalVector = 32'hBFC0_0380; // Boot base plus 0x180

    logic                  clock;
    logic                  reset;
    pipeExcPkg::cp0AccessT access;
    pipeExcPkg::excRaiseT  raise;
    pipeExcPkg::stageInfoT idInfo;
    pipeExcPkg::stageInfoT exInfo;
    pipeExcPkg::stageInfoT memInfo;
    logic                  ifIsBd;
    logic                  ifCanErr;
    cp0RegsPkg::dataT      badAddrIf;
    cp0RegsPkg::dataT      badAddrMem;
    logic                  ifStall;
    logic                  idStall;
    logic                  idIsFlushed;
    logic [4:0]            hwInt;
    cp0RegsPkg::dataT      readData;
    logic                  kernelMode;
    pipeExcPkg::stageCtrlT control;
    cp0RegsPkg::dataT      excPc;
    logic                  excPcSel;
    logic [7:0]            pending;
    int                    seed = 31220;

    `include "cpZeroChecks.svh"

    cpZero cpZero_inst (
        .clock, .reset, .access, .raise, .idInfo, .exInfo, .memInfo, .ifIsBd, .ifCanErr,
        .badAddrIf, .badAddrMem, .ifStall, .idStall, .idIsFlushed, .hwInt, .readData,
        .kernelMode, .control, .excPc, .excPcSel, .pending
    );

    always #(clockPeriod / 2) clock = ~clock;

    task automatic resetTest();
        cp0RegsPkg::dataT value;
        startTest("reset");
        reset = 1'b1;
        repeat (resetCycles) @(posedge clock);
        #1;
        checkFlag("excPcSel in reset", 1'b1, excPcSel);
        checkData("excPc in reset", 32'hBFC0_0000, excPc);
        reset = 1'b0;
        #1;
        checkCtrl("first cycle", makeCtrl(4'b0000, 4'b0001), control); // IF refetch
        nextCycle();
        checkCtrl("idle control", makeCtrl(4'b0000, 4'b0000), control);
        checkFlag("kernelMode", 1'b1, kernelMode);
        readReg(`CP0_REG_STATUS, value);
        checkData("Status", statusReset, value);
        finishTest();
    endtask

    task automatic registerTest();
        cp0RegsPkg::dataT epcData;
        cp0RegsPkg::dataT compareData;
        cp0RegsPkg::dataT statusData;
        cp0RegsPkg::dataT value;
        startTest("mtc0 readback");
        epcData     = $random(seed);
        compareData = $random(seed);
        statusData  = $random(seed) & ~32'h0000_0011; // Keep kernel mode, IE off
        writeReg(`CP0_REG_EPC, epcData);
        writeReg(`CP0_REG_COMPARE, compareData);
        writeReg(`CP0_REG_STATUS, statusData);
        readReg(`CP0_REG_EPC, value);
        checkData("EPC", epcData, value);
        readReg(`CP0_REG_COMPARE, value);
        checkData("Compare", compareData, value);
        readReg(`CP0_REG_STATUS, value);
        checkData("Status", statusData & statusLive, value);
        writeReg(`CP0_REG_STATUS, statusReset);
        finishTest();
    endtask

    task automatic syscallTest();
        cp0RegsPkg::dataT value;
        cp0RegsPkg::dataT restartPc;
        startTest("syscall and eret");
        restartPc        = 32'h8000_1040;
        raise.sys        = 1'b1;
        idInfo.restartPc = restartPc;
        #2;
        checkCtrl("control", makeCtrl(4'b0000, 4'b0011), control); // ID and IF flushed
        checkFlag("excPcSel", 1'b1, excPcSel);
        checkData("excPc", generalVector, excPc);
        nextCycle();
        idleInputs();
        readReg(`CP0_REG_CAUSE, value);
        checkCode("ExcCode", cp0RegsPkg::SYS, cp0RegsPkg::excCodeT'(value[6:2]));
        readReg(`CP0_REG_EPC, value);
        checkData("EPC", restartPc, value);
        readReg(`CP0_REG_STATUS, value);
        checkData("Status with EXL", statusReset | statusExl, value);
        access.eret = 1'b1;
        #2;
        checkFlag("eret excPcSel", 1'b1, excPcSel);
        checkData("eret excPc", restartPc, excPc);
        nextCycle();
        access = '0;
        readReg(`CP0_REG_STATUS, value);
        checkData("Status after eret", statusReset, value);
        finishTest();
    endtask

    task automatic arbitrationTest();
        cp0RegsPkg::dataT value;
        startTest("priority and stall");
        raise.adEl        = 1'b1; // MEM and ID fault together
        raise.sys         = 1'b1;
        memInfo.restartPc = 32'h8000_2000;
        badAddrMem        = 32'h1234_5677;
        idInfo.restartPc  = 32'h8000_200C;
        #2;
        checkCtrl("control", makeCtrl(4'b0000, 4'b1111), control);
        nextCycle();
        idleInputs();
        readReg(`CP0_REG_CAUSE, value);
        checkCode("ExcCode", cp0RegsPkg::ADEL, cp0RegsPkg::excCodeT'(value[6:2]));
        readReg(`CP0_REG_BADVADDR, value);
        checkData("BadVAddr", 32'h1234_5677, value);
        readReg(`CP0_REG_EPC, value);
        checkData("EPC", 32'h8000_2000, value);
        returnFromException();
        memInfo.canErr   = 1'b1; // MEM may still fault
        raise.sys        = 1'b1;
        idInfo.restartPc = 32'h8000_3000;
        #2;
        checkCtrl("waiting control", makeCtrl(4'b0010, 4'b0011), control);
        checkFlag("waiting excPcSel", 1'b0, excPcSel);
        nextCycle();
        idleInputs();
        readReg(`CP0_REG_EPC, value);
        checkData("EPC kept", 32'h8000_2000, value);
        readReg(`CP0_REG_STATUS, value);
        checkData("Status kept", statusReset, value);
        finishTest();
    endtask

    task automatic interruptTest();
        cp0RegsPkg::dataT value;
        int               waited;
        startTest("interrupts");
        writeReg(`CP0_REG_STATUS, statusReset | 32'h0000_0401); // IM2 and IE
        idInfo.restartPc = 32'h8000_4000;
        hwInt            = 5'b00001; // Lands in IP2
        #2;
        checkFlag("IP2 same cycle", 1'b0, pending[2]);
        checkFlag("no early redirect", 1'b0, excPcSel);
        nextCycle();
        #2;
        checkFlag("IP2", 1'b1, pending[2]);
        checkFlag("interrupt excPcSel", 1'b1, excPcSel);
        checkData("interrupt excPc", generalVector, excPc);
        nextCycle();
        idleInputs();
        readReg(`CP0_REG_CAUSE, value);
        checkCode("ExcCode", cp0RegsPkg::INT, cp0RegsPkg::excCodeT'(value[6:2]));
        readReg(`CP0_REG_EPC, value);
        checkData("EPC", 32'h8000_4000, value);
        writeReg(`CP0_REG_STATUS, statusReset);
        readReg(`CP0_REG_COUNT, value);
        writeReg(`CP0_REG_COMPARE, value + 32'd20); // A few cycles ahead of Count
        checkFlag("IP7 cleared", 1'b0, pending[7]);
        waited = 0;
        while (!pending[7] && waited < 100) begin
            nextCycle();
            waited++;
        end
        if (!pending[7])
            reportFailure("pending bit 7 never rose after Count reached Compare");
        writeReg(`CP0_REG_COMPARE, value); // Already passed, so no new hit
        checkFlag("IP7 after rewrite", 1'b0, pending[7]);
        finishTest();
    endtask

    task automatic userModeTest();
        cp0RegsPkg::dataT value;
        startTest("user mode");
        writeReg(`CP0_REG_STATUS, statusReset | 32'h0000_0010);
        checkFlag("kernelMode", 1'b0, kernelMode);
        idInfo.restartPc = 32'h8000_5000;
        access.mfc0      = 1'b1;
        access.rd        = `CP0_REG_STATUS;
        #2;
        checkData("user mfc0", 32'h0, readData);
        checkFlag("mfc0 CpU redirect", 1'b1, excPcSel);
        nextCycle();
        idleInputs();
        checkFlag("kernel at EXL", 1'b1, kernelMode);
        returnFromException(); // Back to user mode
        checkFlag("user again", 1'b0, kernelMode);
        idInfo.restartPc = 32'h8000_6000;
        access.mtc0      = 1'b1;
        access.rd        = `CP0_REG_EPC;
        access.writeData = 32'h1111_2222;
        #2;
        checkCtrl("mtc0 control", makeCtrl(4'b0000, 4'b0011), control);
        nextCycle();
        idleInputs();
        readReg(`CP0_REG_CAUSE, value);
        checkCode("ExcCode", cp0RegsPkg::CPU, cp0RegsPkg::excCodeT'(value[6:2]));
        readReg(`CP0_REG_EPC, value);
        checkData("EPC", 32'h8000_6000, value); // Exception PC, not the write data
        writeReg(`CP0_REG_STATUS, statusReset);
        finishTest();
    endtask

    initial begin
        clock = 1'b0;
        reset = 1'b1;
        idleInputs();
        resetTest();
        registerTest();
        syscallTest();
        arbitrationTest();
        interruptTest();
        userModeTest();
        $display("Tests run %0d, failed %0d, checks %0d, errors %0d",
                 testsRun, testsFailed, checkCount, errorCount);
        if (testsFailed == 0 && errorCount == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

    // Watchdog
    initial begin
        #(clockPeriod * (resetCycles + testCount * cyclesPerTest));
        $display("Timeout after %0d cycles, tests did not finish",
                 resetCycles + testCount * cyclesPerTest);
        $display("Some tests failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: sim.f
+incdir+design
+incdir+bench
design/cp0RegsPkg.sv
design/pipeExcPkg.sv
design/exceptionArbiter.sv
design/cp0RegisterFile.sv
design/exceptionVector.sv
design/cpZero.sv
bench/cpZeroTb.sv

// File: Makefile
TOP = cpZeroTb

.PHONY: compile run clean

compile:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f sim.f --Mdir obj_dir

run: compile
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "All tests passed"

clean:
	rm -rf obj_dir
